//--- common/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address width
`define CPU_XLEN 16

// Architectural registers, R0 included
`define CPU_NREGS 16

// Words in each of the instruction and data memories
`define CPU_MEM_WORDS 256

`endif

//--- common/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [`CPU_XLEN-1:0] word_t;
  typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

  // Upper nibble of every instruction
  typedef enum logic [3:0] {
    OP_ADD = 4'b0000,
    OP_SUB = 4'b0001,
    OP_XOR = 4'b0010,
    OP_SLL = 4'b0100,
    OP_SRA = 4'b0101,
    OP_LW  = 4'b1000,
    OP_SW  = 4'b1001,
    OP_LLB = 4'b1010,
    OP_LHB = 4'b1011,
    OP_B   = 4'b1100,
    OP_BR  = 4'b1101,
    OP_NOP = 4'b1110,
    OP_HLT = 4'b1111
  } opcode_e;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  // All zero is a bubble
  typedef struct packed {
    opcode_e alu_op;
    logic    alu_imm;    // ALU in2 from the immediate field
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
    logic    branch;     // B with a pc relative target
    logic    branch_reg; // BR to a register target
    logic    halt;
    logic    set_zn;
    logic    set_v;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc_plus_2;
  } if_id_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    op1;
    word_t    op2;
    word_t    offset; // Shift count or scaled memory offset
    reg_idx_t dst;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu_result;
    word_t    store_data;
    reg_idx_t dst;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t    ctrl;
    word_t    alu_result;
    word_t    read_data;
    reg_idx_t dst;
  } mem_wb_t;

  // Retire trace
  typedef struct packed {
    logic     valid;
    reg_idx_t dst;
    word_t    data;
  } wb_t;

endpackage

//--- hw/memory1c.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module memory1c import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  word_t addr,
  input  word_t data_in,
  input  logic  write,
  output word_t data_out
);

  localparam int IDX_BITS = $clog2(`CPU_MEM_WORDS);

  word_t               mem [`CPU_MEM_WORDS];
  logic [IDX_BITS-1:0] idx;

  // Word index without the byte bit
  assign idx      = addr[IDX_BITS:1];
  assign data_out = mem[idx];

  always @(posedge clk) begin
    if (rst_n && write) begin  // No stores while in reset
      mem[idx] <= data_in;
    end
  end

endmodule

//--- hw/alu.sv
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
  input  opcode_e op,
  input  word_t   in1,
  input  word_t   in2,
  output word_t   result,
  output flags_t  flags
);

  localparam int    MSB     = $bits(word_t) - 1;
  localparam int    SHW     = $clog2($bits(word_t));
  localparam word_t SAT_POS = {1'b0, {MSB{1'b1}}};
  localparam word_t SAT_NEG = {1'b1, {MSB{1'b0}}};

  word_t          sum;
  word_t          diff;
  logic           add_ovf;
  logic           sub_ovf;
  logic           ovf;
  logic [SHW-1:0] shamt;

  assign sum     = in1 + in2;
  assign diff    = in1 - in2;
  assign shamt   = in2[SHW-1:0];
  assign add_ovf = (in1[MSB] == in2[MSB]) && (sum[MSB] != in1[MSB]);
  assign sub_ovf = (in1[MSB] != in2[MSB]) && (diff[MSB] != in1[MSB]);

  always_comb begin
    ovf    = 1'b0;
    result = in1;
    case (op)
      OP_ADD: begin
        ovf    = add_ovf;
        result = add_ovf ? (in1[MSB] ? SAT_NEG : SAT_POS) : sum;  // Clamp
      end
      OP_SUB: begin
        ovf    = sub_ovf;
        result = sub_ovf ? (in1[MSB] ? SAT_NEG : SAT_POS) : diff;
      end
      OP_XOR:         result = in1 ^ in2;
      OP_SLL:         result = in1 << shamt;
      OP_SRA:         result = word_t'($signed(in1) >>> shamt);
      OP_LW, OP_SW:   result = sum;        // Address wraps around
      OP_LLB, OP_LHB: result = in1 | in2;  // Halves prepared in decode
      default:        result = in1;
    endcase
  end

  assign flags = '{z: (result == '0), v: ovf, n: result[MSB]};

endmodule

//--- hw/register_file.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t src_reg1,
  input  reg_idx_t src_reg2,
  input  reg_idx_t dst_reg,
  input  logic     write,
  input  word_t    dst_data,
  output word_t    src_data1,
  output word_t    src_data2
);

  word_t regs [`CPU_NREGS];

  // Same-cycle write shows through on reads
  function automatic word_t read_port(input reg_idx_t sel);
    word_t val;
    if (sel == '0) begin
      val = '0;
    end else if (write && sel == dst_reg) begin
      val = dst_data;
    end else begin
      val = regs[sel];
    end
    return val;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write && dst_reg != '0) begin
      regs[dst_reg] <= dst_data;
    end
  end

  always_comb begin
    src_data1 = read_port(src_reg1);
    src_data2 = read_port(src_reg2);
  end

endmodule

//--- hw/control_unit.sv
`timescale 1ns/100ps

module control_unit import cpu_pkg::*; (
  input  word_t    instr,
  output ctrl_t    ctrl,
  output reg_idx_t src_reg1,
  output reg_idx_t src_reg2,
  output reg_idx_t dst_reg
);

  opcode_e op;

  assign op = opcode_e'(instr[15:12]);

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = OP_NOP;
    src_reg1    = instr[7:4];
    src_reg2    = instr[3:0];
    dst_reg     = instr[11:8];
    case (op)
      OP_ADD, OP_SUB: begin
        ctrl.alu_op    = op;
        ctrl.reg_write = 1'b1;
        ctrl.set_zn    = 1'b1;
        ctrl.set_v     = 1'b1;
      end
      OP_XOR, OP_SLL, OP_SRA: begin
        ctrl.alu_op    = op;
        ctrl.alu_imm   = (op != OP_XOR);  // Shift count from the instruction
        ctrl.reg_write = 1'b1;
        ctrl.set_zn    = 1'b1;
      end
      OP_LW: begin
        ctrl.alu_op     = op;
        ctrl.alu_imm    = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      OP_SW: begin
        ctrl.alu_op    = op;
        ctrl.alu_imm   = 1'b1;
        ctrl.mem_write = 1'b1;
        src_reg2       = instr[11:8];  // Store data register
      end
      OP_LLB, OP_LHB: begin
        ctrl.alu_op    = op;
        ctrl.reg_write = 1'b1;
        src_reg1       = instr[11:8];  // Old value of rd
      end
      OP_B:    ctrl.branch     = 1'b1;
      OP_BR:   ctrl.branch_reg = 1'b1;
      OP_HLT:  ctrl.halt       = 1'b1;
      default: ;  // NOP and unused codes
    endcase
    if (dst_reg == '0) ctrl.reg_write = 1'b0;
  end

endmodule

//--- hw/cpu.sv
`timescale 1ns/100ps

module cpu import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output logic  hlt,
  output word_t pc,
  output wb_t   wb
);

  if_id_t   if_id;
  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  mem_wb_t  mem_wb;

  word_t    instr;
  word_t    pc_plus_2;
  opcode_e  id_op;
  ctrl_t    id_ctrl;
  reg_idx_t src_reg1;
  reg_idx_t src_reg2;
  reg_idx_t dst_reg;
  word_t    src_data1;
  word_t    src_data2;
  word_t    id_op1;
  word_t    id_op2;
  word_t    id_offset;
  word_t    br_target;
  logic     br_taken;
  logic     id_halt;
  logic     halt_seen;
  flags_t   flags_q;
  flags_t   alu_flags;
  word_t    alu_in2;
  word_t    alu_result;
  word_t    dmem_rdata;
  word_t    wb_data;

  // Condition codes of B and BR
  function automatic logic cond_met(input logic [2:0] ccc, input flags_t f);
    logic met;
    case (ccc)
      3'b000:  met = !f.z;          // Not equal
      3'b001:  met = f.z;           // Equal
      3'b010:  met = !f.z && !f.n;  // Greater than
      3'b011:  met = f.n;           // Less than
      3'b100:  met = f.z || !f.n;   // Greater or equal
      3'b101:  met = f.z || f.n;    // Less or equal
      3'b110:  met = f.v;           // Overflow
      default: met = 1'b1;          // Unconditional
    endcase
    return met;
  endfunction

  ////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////
  memory1c instruction_mem (
    .clk,
    .rst_n,
    .addr(pc),
    .data_in('0),
    .write(1'b0),
    .data_out(instr)
  );

  assign pc_plus_2 = pc + word_t'(2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc        <= '0;
      halt_seen <= 1'b0;
    end else begin
      halt_seen <= halt_seen | id_halt;
      if (!(halt_seen || id_halt)) begin  // PC frozen once HLT decodes
        pc <= br_taken ? br_target : pc_plus_2;
      end
    end
  end

  always_ff @(posedge clk) begin
    if_id.instr     <= instr;
    if_id.pc_plus_2 <= pc_plus_2;
    if (!rst_n) begin
      if_id.valid <= 1'b0;
    end else begin
      if_id.valid <= !(br_taken || id_halt || halt_seen); // Flush shadow slot
    end
  end

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  control_unit control (
    .instr(if_id.instr),
    .ctrl(id_ctrl),
    .src_reg1,
    .src_reg2,
    .dst_reg
  );

  register_file regfile (
    .clk,
    .rst_n,
    .src_reg1,
    .src_reg2,
    .dst_reg(mem_wb.dst),
    .write(mem_wb.ctrl.reg_write),
    .dst_data(wb_data),
    .src_data1,
    .src_data2
  );

  assign id_op = opcode_e'(if_id.instr[15:12]);

  // Byte loads merge the immediate into the kept half of rd
  always_comb begin
    id_op1 = src_data1;
    id_op2 = src_data2;
    if (id_op == OP_LLB) begin
      id_op1 = src_data1 & 16'hFF00;
      id_op2 = {8'h00, if_id.instr[7:0]};
    end else if (id_op == OP_LHB) begin
      id_op1 = src_data1 & 16'h00FF;
      id_op2 = {if_id.instr[7:0], 8'h00};
    end
  end

  assign id_offset = (id_ctrl.mem_read || id_ctrl.mem_write) ?
                     {{11{if_id.instr[3]}}, if_id.instr[3:0], 1'b0} :
                     {12'h000, if_id.instr[3:0]};

  assign br_taken  = if_id.valid && (id_ctrl.branch || id_ctrl.branch_reg) &&
                     cond_met(if_id.instr[11:9], flags_q);
  assign br_target = id_ctrl.branch_reg ? src_data1 :
                     if_id.pc_plus_2 + {{6{if_id.instr[8]}}, if_id.instr[8:0], 1'b0};
  assign id_halt   = if_id.valid && id_ctrl.halt;

  always_ff @(posedge clk) begin
    id_ex.op1    <= id_op1;
    id_ex.op2    <= id_op2;
    id_ex.offset <= id_offset;
    id_ex.dst    <= dst_reg;
    if (!rst_n) begin
      id_ex.ctrl <= '0;
    end else begin
      id_ex.ctrl <= if_id.valid ? id_ctrl : ctrl_t'('0);
    end
  end

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////
  assign alu_in2 = id_ex.ctrl.alu_imm ? id_ex.offset : id_ex.op2;

  alu u_alu (
    .op(id_ex.ctrl.alu_op),
    .in1(id_ex.op1),
    .in2(alu_in2),
    .result(alu_result),
    .flags(alu_flags)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else begin
      if (id_ex.ctrl.set_zn) flags_q.z <= alu_flags.z;
      if (id_ex.ctrl.set_v) begin  // N only moves with ADD and SUB
        flags_q.v <= alu_flags.v;
        flags_q.n <= alu_flags.n;
      end
    end
  end

  always_ff @(posedge clk) begin
    ex_mem.alu_result <= alu_result;
    ex_mem.store_data <= id_ex.op2;
    ex_mem.dst        <= id_ex.dst;
    if (!rst_n) begin
      ex_mem.ctrl <= '0;
    end else begin
      ex_mem.ctrl <= id_ex.ctrl;
    end
  end

  ////////////////////////////////////////
  // Memory and write-back
  ////////////////////////////////////////
  memory1c data_mem (
    .clk,
    .rst_n,
    .addr(ex_mem.alu_result),
    .data_in(ex_mem.store_data),
    .write(ex_mem.ctrl.mem_write),
    .data_out(dmem_rdata)
  );

  always_ff @(posedge clk) begin
    mem_wb.alu_result <= ex_mem.alu_result;
    mem_wb.read_data  <= ex_mem.ctrl.mem_read ? dmem_rdata : '0;
    mem_wb.dst        <= ex_mem.dst;
    if (!rst_n) begin
      mem_wb.ctrl <= '0;
      hlt         <= 1'b0;
    end else begin
      mem_wb.ctrl <= ex_mem.ctrl;
      if (ex_mem.ctrl.halt) hlt <= 1'b1; // High as HLT enters write-back
    end
  end

  assign wb_data  = mem_wb.ctrl.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;

  assign wb.valid = mem_wb.ctrl.reg_write;
  assign wb.dst   = mem_wb.dst;
  assign wb.data  = wb_data;

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic por_n
);

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  initial begin
    por_n = 1'b0;
    repeat (2) @(posedge clk);
    por_n = 1'b1;
  end

endmodule

//--- testbench/cpu_properties.sv
`timescale 1ns/100ps

module cpu_properties import cpu_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  hlt,
  input word_t pc,
  input wb_t   wb
);

  int failures = 0;  // Count of failed assertions

  // Outputs come out of reset quiet
  quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !hlt && !wb.valid)
    else begin
      failures++;
      $error("hlt or wb.valid high in the cycle after reset");
    end

  // Halted core keeps its PC
  pc_frozen_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
    hlt |=> $stable(pc))
    else begin
      failures++;
      $error("pc moved while hlt was high");
    end

  retire_has_dst: assert property (@(posedge clk) disable iff (!rst_n)
    wb.valid |-> wb.dst != '0)
    else begin
      failures++;
      $error("retire to r0");
    end

endmodule

//--- testbench/cpu_tb.sv
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpu_tb import cpu_pkg::*; ();

  localparam int    TIMEOUT_CYCLES = 500;  // Five tests of at most 60 cycles plus reset margin
  localparam word_t NOP_W = {OP_NOP, 12'h000};
  localparam word_t HLT_W = {OP_HLT, 12'h000};

  logic   clk;
  logic   por_n;
  logic   rst_req;
  logic   rst_n;
  logic   hlt;
  word_t  pc;
  wb_t    wb;

  int     errors = 0;
  int     checks = 0;
  int     tests  = 0;
  int     cycles = 0;
  int     seed   = 32'h756ec757;

  word_t  prog [$];
  wb_t    exp_wb [$];
  word_t  exp_pc [$];  // Fetch address of each expected retire
  word_t  halt_pc;

  assign rst_n = por_n & rst_req;

  tb_clock_gen clock_gen (.clk, .por_n);

  cpu dut (.clk, .rst_n, .hlt, .pc, .wb);

  bind cpu cpu_properties props (.clk(clk), .rst_n(rst_n), .hlt(hlt), .pc(pc), .wb(wb));

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////
  function automatic word_t rrr_instr(opcode_e op, logic [3:0] a, logic [3:0] b,
                                      logic [3:0] c);
    return {op, a, b, c};
  endfunction

  function automatic word_t byte_instr(opcode_e op, logic [3:0] rd, logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic word_t branch_instr(logic [2:0] ccc, logic [8:0] imm);
    return {OP_B, ccc, imm};
  endfunction

  function automatic word_t jump_reg_instr(logic [2:0] ccc, logic [3:0] rs);
    return {OP_BR, ccc, 1'b0, rs, 4'h0};
  endfunction

  // NOP opcode with the word index in the low bits
  function automatic word_t fill_word(int i);
    return {4'hE, 4'h0, i[7:0]};
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic cond_holds(logic [2:0] ccc, logic z, logic v, logic n);
    case (ccc)
      3'd0:    return !z;
      3'd1:    return z;
      3'd2:    return !z && !n;
      3'd3:    return n;
      3'd4:    return z || !n;
      3'd5:    return z || n;
      3'd6:    return v;
      default: return 1'b1;
    endcase
  endfunction

  task automatic run_model();
    word_t   r [16];
    word_t   dmem [`CPU_MEM_WORDS];
    word_t   pc_m;
    word_t   next;
    word_t   ins;
    word_t   a;
    word_t   b;
    word_t   val;
    word_t   addr;
    wb_t     e;
    opcode_e op;
    logic    fz;
    logic    fv;
    logic    fn;
    logic    wr;
    logic    stop;
    int      sum;
    int      steps;
    foreach (r[i]) r[i] = '0;
    foreach (dmem[i]) dmem[i] = '0;
    exp_wb.delete();
    exp_pc.delete();
    pc_m  = '0;
    fz    = 1'b0;
    fv    = 1'b0;
    fn    = 1'b0;
    stop  = 1'b0;
    steps = 0;
    while (!stop && steps < 200) begin
      ins  = (pc_m[8:1] < prog.size()) ? prog[pc_m[8:1]] : fill_word(pc_m[8:1]);
      op   = opcode_e'(ins[15:12]);
      a    = r[ins[7:4]];
      b    = r[ins[3:0]];
      wr   = 1'b0;
      val  = '0;
      next = pc_m + 16'd2;
      case (op)
        OP_ADD, OP_SUB: begin
          sum = (op == OP_ADD) ? $signed(a) + $signed(b) : $signed(a) - $signed(b);
          fv  = (sum > 32767) || (sum < -32768);
          if (sum > 32767) sum = 32767;
          else if (sum < -32768) sum = -32768;
          val = word_t'(sum);
          fn  = val[15];
          fz  = (val == '0);
          wr  = 1'b1;
        end
        OP_XOR, OP_SLL, OP_SRA: begin
          if (op == OP_XOR) val = a ^ b;
          else if (op == OP_SLL) val = a << ins[3:0];
          else val = word_t'($signed(a) >>> ins[3:0]);
          fz = (val == '0);  // Only Z moves
          wr = 1'b1;
        end
        OP_LW, OP_SW: begin
          addr = a + {{11{ins[3]}}, ins[3:0], 1'b0};
          if (op == OP_SW) dmem[addr[8:1]] = r[ins[11:8]];
          val = dmem[addr[8:1]];
          wr  = (op == OP_LW);
        end
        OP_LLB: begin
          val = {r[ins[11:8]][15:8], ins[7:0]};
          wr  = 1'b1;
        end
        OP_LHB: begin
          val = {ins[7:0], r[ins[11:8]][7:0]};
          wr  = 1'b1;
        end
        OP_B: if (cond_holds(ins[11:9], fz, fv, fn)) next = next + {{6{ins[8]}}, ins[8:0], 1'b0};
        OP_BR: if (cond_holds(ins[11:9], fz, fv, fn)) next = a;
        OP_HLT: begin
          stop    = 1'b1;
          halt_pc = pc_m;
        end
        default: ;
      endcase
      if (wr && ins[11:8] != 4'd0) begin
        r[ins[11:8]] = val;
        e.valid = 1'b1;
        e.dst   = ins[11:8];
        e.data  = val;
        exp_wb.push_back(e);
        exp_pc.push_back(pc_m);
      end
      pc_m = next;
      steps++;
    end
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_wb(input wb_t got, input wb_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t: %s got r%0d=%h, expected r%0d=%h", $time, what,
               got.dst, got.data, exp.dst, exp.data);
      errors++;
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      $display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Program loading and run
  ////////////////////////////////////////
  task automatic apply_reset();
    @(negedge clk);
    rst_req = 1'b0;
    for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
      dut.instruction_mem.mem[i] = (i < prog.size()) ? prog[i] : fill_word(i);
      dut.data_mem.mem[i]        = '0;  // Unwritten data reads zero
    end
    repeat (2) @(negedge clk);
    check_word(pc, '0, "pc in reset");
    if (hlt !== 1'b0 || wb.valid !== 1'b0) begin
      $display("ERR %0t: hlt or wb.valid not low during reset", $time);
      errors++;
    end
    rst_req = 1'b1;
  endtask

  task automatic run_and_compare(input string name);
    word_t pc_hist [$];
    word_t frozen;
    int    k;
    int    idx;
    int    err_before;
    logic  done;
    err_before = errors;
    run_model();
    apply_reset();
    k    = 0;
    idx  = 0;
    done = 1'b0;
    while (!done) begin
      pc_hist.push_back(pc);
      if (k == 0) check_word(pc, '0, "pc after reset");
      if (wb.valid) begin
        if (idx >= exp_wb.size()) begin
          $display("%0t: unexpected retire to r%0d", $time, wb.dst);
          errors++;
        end else begin
          check_wb(wb, exp_wb[idx], "retire");
          if (k >= 4) check_word(pc_hist[k-4], exp_pc[idx], "fetch pc four cycles earlier");
          else begin
            $display("%0t: retire came less than four cycles after reset", $time);
            errors++;
          end
          idx++;
        end
      end
      if (hlt) begin
        done = 1'b1;
        if (idx != exp_wb.size()) begin
          $display("%0t: halted after %0d of %0d retires", $time, idx, exp_wb.size());
          errors++;
        end
        if (k >= 4) check_word(pc_hist[k-4], halt_pc, "fetch pc of HLT");
      end else begin
        k++;
        @(negedge clk);
      end
    end
    frozen = pc;
    repeat (6) begin
      @(negedge clk);
      check_word(pc, frozen, "pc after halt");
      if (wb.valid || !hlt) begin
        $display("ERR %0t: retire after halt or hlt dropped", $time);
        errors++;
      end
    end
    tests++;
    $display("%s: %s (%0d errors)", name, (errors == err_before) ? "ok" : "FAIL",
             errors - err_before);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic reset_test();
    prog = '{NOP_W, NOP_W, NOP_W, NOP_W, HLT_W};
    run_and_compare("reset");
  endtask

  task automatic arith_test();
    word_t c [3];
    foreach (c[i]) c[i] = word_t'($random(seed));
    prog = '{byte_instr(OP_LLB, 1, c[0][7:0]), byte_instr(OP_LLB, 2, c[1][7:0]),
             byte_instr(OP_LLB, 3, 8'h00),     byte_instr(OP_LLB, 4, 8'hFF),
             byte_instr(OP_LLB, 5, 8'h01),     byte_instr(OP_LHB, 1, c[0][15:8]),
             byte_instr(OP_LHB, 2, c[1][15:8]), byte_instr(OP_LHB, 3, 8'h80),
             byte_instr(OP_LHB, 4, 8'h7F),     byte_instr(OP_LHB, 5, 8'h00),
             rrr_instr(OP_ADD, 6, 1, 2),       rrr_instr(OP_SUB, 7, 1, 2),
             rrr_instr(OP_ADD, 0, 1, 2),       // Result to R0 is dropped
             rrr_instr(OP_XOR, 9, 1, 2),       rrr_instr(OP_SLL, 10, 1, c[2][3:0]),
             rrr_instr(OP_SRA, 11, 2, c[2][7:4]),
             rrr_instr(OP_ADD, 8, 4, 5),       // 7FFF + 1 clamps high
             rrr_instr(OP_SUB, 12, 3, 5),      // 8000 - 1 clamps low
             rrr_instr(OP_ADD, 13, 3, 3),
             rrr_instr(OP_XOR, 14, 0, 1),      // R0 reads zero
             HLT_W};
    run_and_compare("arithmetic");
  endtask

  task automatic memory_test();
    word_t c [3];
    foreach (c[i]) c[i] = word_t'($random(seed));
    prog = '{byte_instr(OP_LLB, 1, 8'h20),
             byte_instr(OP_LLB, 2, c[0][7:0]), byte_instr(OP_LLB, 3, c[1][7:0]),
             byte_instr(OP_LLB, 4, c[2][7:0]), byte_instr(OP_LHB, 2, c[0][15:8]),
             byte_instr(OP_LHB, 3, c[1][15:8]), byte_instr(OP_LHB, 4, c[2][15:8]),
             rrr_instr(OP_SW, 2, 1, 4'h0),     rrr_instr(OP_SW, 3, 1, 4'h1),
             rrr_instr(OP_SW, 4, 1, 4'hE),     // Negative offset
             rrr_instr(OP_LW, 5, 1, 4'h0),     rrr_instr(OP_LW, 6, 1, 4'h1),
             rrr_instr(OP_LW, 7, 1, 4'hE),     rrr_instr(OP_LW, 8, 1, 4'h3),
             HLT_W};
    run_and_compare("memory");
  endtask

  task automatic branch_test();
    prog = '{byte_instr(OP_LLB, 1, 8'h05), byte_instr(OP_LLB, 2, 8'h05),
             byte_instr(OP_LLB, 3, 8'h07), NOP_W,
             rrr_instr(OP_SUB, 4, 1, 2),   NOP_W, NOP_W,  // Z set
             branch_instr(3'd1, 9'd1),     byte_instr(OP_LLB, 5, 8'hAA),
             branch_instr(3'd0, 9'd1),     byte_instr(OP_LLB, 6, 8'h11),
             branch_instr(3'd4, 9'd1),     byte_instr(OP_LLB, 5, 8'hBB),
             branch_instr(3'd3, 9'd1),     byte_instr(OP_LLB, 7, 8'h22),
             rrr_instr(OP_SUB, 8, 1, 3),   NOP_W, NOP_W,  // N set
             branch_instr(3'd3, 9'd1),     byte_instr(OP_LLB, 5, 8'hCC),
             branch_instr(3'd2, 9'd1),     byte_instr(OP_LLB, 9, 8'h33),
             branch_instr(3'd7, 9'd1),     byte_instr(OP_LLB, 5, 8'hCD),
             byte_instr(OP_LLB, 10, 8'h3C), NOP_W, NOP_W,
             jump_reg_instr(3'd7, 10),     byte_instr(OP_LLB, 5, 8'hDD),
             byte_instr(OP_LLB, 11, 8'hEE),
             byte_instr(OP_LLB, 11, 8'h44), HLT_W};
    run_and_compare("branches");
  endtask

  task automatic halt_test();
    prog = '{byte_instr(OP_LLB, 1, 8'h12), byte_instr(OP_LLB, 2, 8'h34),
             NOP_W, NOP_W, rrr_instr(OP_ADD, 3, 1, 2), HLT_W,
             byte_instr(OP_LLB, 4, 8'h55), byte_instr(OP_LLB, 5, 8'h66)};
    run_and_compare("halt");
  endtask

  initial begin
    rst_req = 1'b0;
    reset_test();
    arith_test();
    memory_test();
    branch_test();
    halt_test();
    errors += dut.props.failures;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+common
common/cpu_pkg.sv
hw/memory1c.sv
hw/alu.sv
hw/register_file.sv
hw/control_unit.sv
hw/cpu.sv
testbench/tb_clock_gen.sv
testbench/cpu_properties.sv
testbench/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu16

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - hw/memory1c.sv
      - hw/alu.sv
      - hw/register_file.sv
      - hw/control_unit.sv
      - hw/cpu.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_clock_gen.sv
      - testbench/cpu_properties.sv
      - testbench/cpu_tb.sv
